// File: lane_macros.svh
////////////////////////////////////////////////////////////////////////////
// Lane size constants: data width, register count, index width, slice length
////////////////////////////////////////////////////////////////////////////

`ifndef LANE_MACROS_SVH
`define LANE_MACROS_SVH

`define LANE_DATA_W   32	// Data word width
`define LANE_NUM_REGS 32	// Register file depth
`define LANE_IDX_W    5	// Register index width
`define LANE_MAX_LEN  16	// Max slice length, also mask width

`endif

// File: lane_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Lane types: opcodes, command word views and union, controller states
////////////////////////////////////////////////////////////////////////////

`include "lane_macros.svh"

package lane_pkg;

	// Command codes
	typedef enum logic [3:0] {
		ADD   = 4'h0,
		SUB   = 4'h1,
		AND   = 4'h2,
		XOR   = 4'h3,
		MUL   = 4'h4,	// Low half of product
		CMPLT = 4'h5,	// Unsigned compare into mask
		LDI   = 4'h6,	// Load sign-extended immediate
		MVS   = 4'h7	// Move register to scalar out
	} opcode_e;

	////////////////////////////////////////////////////////////////////////////
	// Command word, two views of the same 32 bits
	////////////////////////////////////////////////////////////////////////////

	// Vector operations, CMPLT and MVS
	typedef struct packed {
		opcode_e                 op;
		logic                    masked;	// Gate writes by mask bit
		logic [3:0]              len_m1;	// Slice length minus one
		logic [`LANE_IDX_W-1:0]  dst;
		logic [`LANE_IDX_W-1:0]  src1;
		logic [`LANE_IDX_W-1:0]  src2;
		logic [7:0]              spare;
	} cmd_vec_t;

	// LDI only
	typedef struct packed {
		opcode_e                 op;
		logic [`LANE_IDX_W-1:0]  dst;
		logic [15:0]             imm;
		logic [6:0]              spare;
	} cmd_imm_t;

	// op sits in the top nibble of both views and picks the view
	typedef union packed {
		cmd_vec_t vec;
		cmd_imm_t imm;
	} cmd_u;

	// Lane controller
	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		DRAIN,
		DONE
	} ctrl_state_e;

endpackage

// File: lane_if.sv
////////////////////////////////////////////////////////////////////////////
// Element issue bus and write-back bus
////////////////////////////////////////////////////////////////////////////

`include "lane_macros.svh"

// One element per cycle while valid, no stall
interface elem_if;
	logic                             valid;
	lane_pkg::opcode_e                op;
	logic                             masked;
	logic [$clog2(`LANE_MAX_LEN)-1:0] elem;	// Element number in slice
	logic [`LANE_IDX_W-1:0]           dst;
	logic [`LANE_IDX_W-1:0]           src1;
	logic [`LANE_IDX_W-1:0]           src2;
	logic [15:0]                      imm;

	modport issue (
		output valid, op, masked, elem, dst, src1, src2, imm
	);
	modport exec (
		input valid, op, masked, elem, dst, src1, src2, imm
	);
endinterface

// Register write plus mask bit write
interface wb_if;
	logic                             we;
	logic [`LANE_IDX_W-1:0]           idx;
	logic [`LANE_DATA_W-1:0]          data;
	logic                             mask_we;
	logic                             mask_bit;
	logic [$clog2(`LANE_MAX_LEN)-1:0] mask_elem;

	modport source (
		output we, idx, data, mask_we, mask_bit, mask_elem
	);
	modport sink (
		input we, idx, data, mask_we, mask_bit, mask_elem
	);
endinterface

// File: lane_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// Lane controller FSM: command accept, slice length decode, commit
////////////////////////////////////////////////////////////////////////////

`include "lane_macros.svh"

module lane_ctrl (
	input  logic                            clock,
	input  logic                            reset,
	input  logic                            cmd_valid,
	input  lane_pkg::cmd_u                  cmd,
	output logic                            start,		// One-cycle kick to counter
	output lane_pkg::cmd_u                  cmd_latched,
	output logic [$clog2(`LANE_MAX_LEN):0]  len,		// Elements in slice
	input  logic                            last,
	output logic                            busy,
	output logic                            commit,
	output logic                            scalar_valid
);

	lane_pkg::ctrl_state_e state;
	logic [1:0]            drain_cnt;
	logic                  accept;

	assign accept = cmd_valid && (state == lane_pkg::IDLE);

	// Held for the whole command
	always_ff @(posedge clock) begin
		if (accept) begin
			cmd_latched <= cmd;
		end
	end

	// LDI and MVS always touch one element
	always_comb begin
		case (cmd_latched.vec.op)
			lane_pkg::LDI, lane_pkg::MVS: len = 5'd1;
			default: len = {1'b0, cmd_latched.vec.len_m1} + 5'd1;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// State machine
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= lane_pkg::IDLE;
			start     <= 1'b0;
			drain_cnt <= 2'd0;
		end else begin
			start <= accept;
			case (state)
				lane_pkg::IDLE: begin
					if (cmd_valid) begin
						state <= lane_pkg::ISSUE;
					end
				end
				lane_pkg::ISSUE: begin
					if (last) begin	// Final element issued
						state     <= lane_pkg::DRAIN;
						drain_cnt <= 2'd0;
					end
				end
				lane_pkg::DRAIN: begin
					// Execute and write-back of the last element
					drain_cnt <= drain_cnt + 2'd1;
					if (drain_cnt == 2'd1) begin
						state <= lane_pkg::DONE;
					end
				end
				default: state <= lane_pkg::IDLE;	// DONE lasts one cycle
			endcase
		end
	end

	assign busy         = (state != lane_pkg::IDLE);
	assign commit       = (state == lane_pkg::DONE);
	assign scalar_valid = commit && (cmd_latched.vec.op == lane_pkg::MVS);

endmodule

// File: slice_counter.sv
////////////////////////////////////////////////////////////////////////////
// Slice index counter: element number and per-element register indexes
////////////////////////////////////////////////////////////////////////////

`include "lane_macros.svh"

module slice_counter (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           start,
	input  lane_pkg::cmd_u                 cmd,
	input  logic [$clog2(`LANE_MAX_LEN):0] len,
	output logic                           last,	// Final element on the bus
	elem_if.issue                          issue
);

	localparam int ELEM_W = $clog2(`LANE_MAX_LEN);
	localparam int IDX_W  = `LANE_IDX_W;

	logic [ELEM_W-1:0] count;
	logic              run;
	logic              is_imm;
	logic [IDX_W-1:0]  base_dst;

	always_ff @(posedge clock) begin
		if (reset) begin
			run   <= 1'b0;
			count <= '0;
		end else if (start) begin
			run   <= 1'b1;
			count <= '0;
		end else if (run) begin
			if (last) begin
				run <= 1'b0;
			end else begin
				count <= count + 1'b1;
			end
		end
	end

	assign last = run && (({1'b0, count} + 1'b1) == len);

	// dst sits in a different place in the immediate view
	assign is_imm   = (cmd.vec.op == lane_pkg::LDI);
	assign base_dst = is_imm ? cmd.imm.dst : cmd.vec.dst;

	assign issue.valid  = run;
	assign issue.op     = cmd.vec.op;
	assign issue.masked = is_imm ? 1'b0 : cmd.vec.masked;
	assign issue.elem   = count;
	assign issue.dst    = base_dst + IDX_W'(count);		// Wraps mod 32
	assign issue.src1   = cmd.vec.src1 + IDX_W'(count);
	assign issue.src2   = cmd.vec.src2 + IDX_W'(count);
	assign issue.imm    = cmd.imm.imm;

endmodule

// File: reg_file.sv
////////////////////////////////////////////////////////////////////////////
// Register file, two registered read ports and one write port
////////////////////////////////////////////////////////////////////////////

`include "lane_macros.svh"

module reg_file (
	input  logic                    clock,
	input  logic                    reset,
	elem_if.exec                    rd,
	wb_if.sink                      wb,
	output logic [`LANE_DATA_W-1:0] rdata1,
	output logic [`LANE_DATA_W-1:0] rdata2
);

	localparam int NUM_REGS = `LANE_NUM_REGS;

	logic [`LANE_DATA_W-1:0] regs [NUM_REGS];

	// Write port
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.we) begin
			regs[wb.idx] <= wb.data;
		end
	end

	// Read ports, data out one cycle after the address
	always_ff @(posedge clock) begin
		if (rd.valid) begin
			rdata1 <= regs[rd.src1];
			rdata2 <= regs[rd.src2];
		end
	end

endmodule

// File: mask_reg.sv
////////////////////////////////////////////////////////////////////////////
// Per-element mask register
////////////////////////////////////////////////////////////////////////////

`include "lane_macros.svh"

module mask_reg (
	input  logic                             clock,
	input  logic                             reset,
	wb_if.sink                               wb,
	input  logic [$clog2(`LANE_MAX_LEN)-1:0] elem,
	output logic                             bit_out
);

	logic [`LANE_MAX_LEN-1:0] mask;

	// All elements enabled out of reset
	always_ff @(posedge clock) begin
		if (reset) begin
			mask <= '1;
		end else if (wb.mask_we) begin
			mask[wb.mask_elem] <= wb.mask_bit;	// CMPLT result
		end
	end

	assign bit_out = mask[elem];

endmodule

// File: vec_alu.sv
////////////////////////////////////////////////////////////////////////////
// Execute stage: operation select, mask gating, write-back, scalar out
////////////////////////////////////////////////////////////////////////////

`include "lane_macros.svh"

module vec_alu (
	input  logic                    clock,
	input  logic                    reset,
	elem_if.exec                    exe,
	input  logic [`LANE_DATA_W-1:0] rdata1,
	input  logic [`LANE_DATA_W-1:0] rdata2,
	input  logic                    mask_bit,
	wb_if.source                    wb,
	output logic [`LANE_DATA_W-1:0] scalar_data
);

	localparam int DATA_W = `LANE_DATA_W;

	// Issue fields lined up with the read data
	logic                             s_valid;
	lane_pkg::opcode_e                s_op;
	logic                             s_masked;
	logic                             s_mask_bit;
	logic [$clog2(`LANE_MAX_LEN)-1:0] s_elem;
	logic [`LANE_IDX_W-1:0]           s_dst;
	logic [15:0]                      s_imm;

	logic [DATA_W-1:0] result;
	logic              writes_reg;
	logic              mask_ok;

	always_ff @(posedge clock) begin
		s_op       <= exe.op;
		s_masked   <= exe.masked;
		s_mask_bit <= mask_bit;
		s_elem     <= exe.elem;
		s_dst      <= exe.dst;
		s_imm      <= exe.imm;
	end

	////////////////////////////////////////////////////////////////////////////
	// Operation
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		writes_reg = 1'b1;
		case (s_op)
			lane_pkg::ADD: result = rdata1 + rdata2;
			lane_pkg::SUB: result = rdata1 - rdata2;
			lane_pkg::AND: result = rdata1 & rdata2;
			lane_pkg::XOR: result = rdata1 ^ rdata2;
			lane_pkg::MUL: result = rdata1 * rdata2;	// Low word kept
			lane_pkg::LDI: result = {{(DATA_W - 16){s_imm[15]}}, s_imm};
			default: begin	// CMPLT and MVS leave the registers alone
				result     = rdata1;
				writes_reg = 1'b0;
			end
		endcase
	end

	assign mask_ok = !s_masked || s_mask_bit;

	// Control
	always_ff @(posedge clock) begin
		if (reset) begin
			s_valid    <= 1'b0;
			wb.we      <= 1'b0;
			wb.mask_we <= 1'b0;
		end else begin
			s_valid    <= exe.valid;
			wb.we      <= s_valid && writes_reg && mask_ok;
			wb.mask_we <= s_valid && (s_op == lane_pkg::CMPLT);
		end
	end

	// Payload
	always_ff @(posedge clock) begin
		wb.idx       <= s_dst;
		wb.data      <= result;
		wb.mask_bit  <= (rdata1 < rdata2);	// Unsigned
		wb.mask_elem <= s_elem;
		if (s_valid && (s_op == lane_pkg::MVS)) begin
			scalar_data <= rdata1;
		end
	end

endmodule

// File: lane_unit.sv
////////////////////////////////////////////////////////////////////////////
// Lane top: controller, slice counter, register file, mask, execute stage
////////////////////////////////////////////////////////////////////////////

`include "lane_macros.svh"

module lane_unit (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    cmd_valid,
	input  logic [31:0]             cmd_word,
	output logic                    busy,
	output logic                    commit,
	output logic                    scalar_valid,
	output logic [`LANE_DATA_W-1:0] scalar_data
);

	elem_if issue_bus ();
	wb_if   wb_bus ();

	lane_pkg::cmd_u                 cmd_in;
	lane_pkg::cmd_u                 cmd_latched;
	logic                           start;
	logic                           last;
	logic [$clog2(`LANE_MAX_LEN):0] len;
	logic                           mask_bit;
	logic [`LANE_DATA_W-1:0]        rdata1;
	logic [`LANE_DATA_W-1:0]        rdata2;

	assign cmd_in = cmd_word;

	////////////////////////////////////////////////////////////////////////////
	// Control and issue
	////////////////////////////////////////////////////////////////////////////

	lane_ctrl lane_ctrl_inst (
		.clock        (clock),
		.reset        (reset),
		.cmd_valid    (cmd_valid),
		.cmd          (cmd_in),
		.start        (start),
		.cmd_latched  (cmd_latched),
		.len          (len),
		.last         (last),
		.busy         (busy),
		.commit       (commit),
		.scalar_valid (scalar_valid)
	);

	slice_counter slice_counter_inst (
		.clock (clock),
		.reset (reset),
		.start (start),
		.cmd   (cmd_latched),
		.len   (len),
		.last  (last),
		.issue (issue_bus.issue)
	);

	////////////////////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////////////////////

	reg_file reg_file_inst (
		.clock  (clock),
		.reset  (reset),
		.rd     (issue_bus.exec),
		.wb     (wb_bus.sink),
		.rdata1 (rdata1),
		.rdata2 (rdata2)
	);

	// Mask bit looked up at issue, carried along by the execute stage
	mask_reg mask_reg_inst (
		.clock   (clock),
		.reset   (reset),
		.wb      (wb_bus.sink),
		.elem    (issue_bus.elem),
		.bit_out (mask_bit)
	);

	vec_alu vec_alu_inst (
		.clock       (clock),
		.reset       (reset),
		.exe         (issue_bus.exec),
		.rdata1      (rdata1),
		.rdata2      (rdata2),
		.mask_bit    (mask_bit),
		.wb          (wb_bus.source),
		.scalar_data (scalar_data)
	);

endmodule

// File: tb_lane_unit.sv
////////////////////////////////////////////////////////////////////////////
// Lane testbench: directed tests, register and mask model, watchdog
////////////////////////////////////////////////////////////////////////////

`include "lane_macros.svh"

module tb_lane_unit;

	localparam int MAX_CYCLES = 4000;	// About 2500 needed by the tests

	logic                    clock;
	logic                    reset;
	logic                    cmd_valid;
	logic [31:0]             cmd_word;
	logic                    busy;
	logic                    commit;
	logic                    scalar_valid;
	logic [`LANE_DATA_W-1:0] scalar_data;

	logic [31:0] model_regs [`LANE_NUM_REGS];
	logic [15:0] model_mask;
	int          cycles;
	int          checks;
	int          errors;
	int          errors_before;

	lane_unit lane_unit_inst (
		.clock        (clock),
		.reset        (reset),
		.cmd_valid    (cmd_valid),
		.cmd_word     (cmd_word),
		.busy         (busy),
		.commit       (commit),
		.scalar_valid (scalar_valid),
		.scalar_data  (scalar_data)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: run still going after %0d clock cycles", MAX_CYCLES);
			$display("TEST FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
			input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Inputs change and outputs are sampled 1 unit after the edge
	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	// From the top: op, masked, len-1, dst, src1, src2, spare
	function automatic logic [31:0] vec_word(lane_pkg::opcode_e op, logic masked, int len,
			logic [4:0] dst, logic [4:0] src1, logic [4:0] src2);
		return {op, masked, 4'(len - 1), dst, src1, src2, 8'h00};
	endfunction

	function automatic logic [31:0] imm_word(logic [4:0] dst, logic [15:0] imm);
		return {lane_pkg::LDI, dst, imm, 7'h00};
	endfunction

	// Source base whose slice stays clear of the destination slice
	function automatic logic [4:0] pick_src(logic [4:0] dst, int len);
		return dst + 5'(len) + 5'($urandom % (33 - 2 * len));
	endfunction

	task automatic model_apply(input logic [31:0] word, output logic exp_sv,
			output logic [31:0] exp_sd);
		lane_pkg::opcode_e op;
		logic [31:0]       a;
		logic [31:0]       b;
		logic [4:0]        d;
		op     = lane_pkg::opcode_e'(word[31:28]);
		exp_sv = (op == lane_pkg::MVS);
		exp_sd = model_regs[word[17:13]];
		if (op == lane_pkg::LDI) begin
			model_regs[word[27:23]] = {{16{word[22]}}, word[22:7]};
		end else if (op != lane_pkg::MVS) begin
			for (int i = 0; i <= int'(word[26:23]); i++) begin
				a = model_regs[5'(word[17:13] + i)];
				b = model_regs[5'(word[12:8] + i)];
				d = 5'(word[22:18] + i);	// Wraps mod 32
				if (op == lane_pkg::CMPLT) begin
					model_mask[i] = (a < b);
				end else if (!word[27] || model_mask[i]) begin
					case (op)
						lane_pkg::ADD: model_regs[d] = a + b;
						lane_pkg::SUB: model_regs[d] = a - b;
						lane_pkg::AND: model_regs[d] = a & b;
						lane_pkg::XOR: model_regs[d] = a ^ b;
						default: model_regs[d] = a * b;	// MUL, low word
					endcase
				end
			end
		end
	endtask

	// Waits for idle, pulses the command and returns in the commit cycle
	task automatic exec_cmd(input logic [31:0] word);
		logic        exp_sv;
		logic [31:0] exp_sd;
		while (busy) next_cycle();
		cmd_word  = word;
		cmd_valid = 1'b1;
		next_cycle();
		cmd_valid = 1'b0;
		while (!commit) next_cycle();
		model_apply(word, exp_sv, exp_sd);
		check_value(scalar_valid, exp_sv, $sformatf("scalar_valid, cmd %h", word));
		if (exp_sv) begin
			check_value(scalar_data, exp_sd, $sformatf("scalar_data, cmd %h", word));
		end
	endtask

	task automatic read_back(input logic [4:0] base, input int len);
		for (int i = 0; i < len; i++) begin
			exec_cmd(vec_word(lane_pkg::MVS, 1'b0, 1, 5'd0, base + 5'(i), 5'd0));
		end
	endtask

	// Commit one cycle after the last write, stray command mid-flight
	task automatic timed_add(input int len);
		logic [4:0]  d;
		logic [4:0]  s;
		logic [31:0] word;
		logic        exp_sv;
		logic [31:0] exp_sd;
		int          n;
		d    = 5'($urandom);
		s    = pick_src(d, len);
		word = vec_word(lane_pkg::ADD, 1'b0, len, d, s, pick_src(d, len));
		while (busy) next_cycle();
		cmd_word  = word;
		cmd_valid = 1'b1;
		next_cycle();
		cmd_word = imm_word(s, 16'h5a5a);
		n = 0;
		while (!commit && n < len + 8) begin
			check_value(busy, 1'b1, "busy while command in flight");
			cmd_valid = (n == 2);
			next_cycle();
			n++;
		end
		cmd_valid = 1'b0;
		check_value(n, len + 3, $sformatf("commit latency, length %0d", len));
		model_apply(word, exp_sv, exp_sd);
		next_cycle();
		check_value(busy, 1'b0, "busy after commit");
		read_back(d, len);
		read_back(s, 1);	// Stray LDI target
	endtask

	task automatic report_test(input string name);
		$display("%-14s finished, %0d mismatches", name, errors - errors_before);
		errors_before = errors;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		lane_pkg::opcode_e all_ops [8] = '{lane_pkg::ADD, lane_pkg::SUB, lane_pkg::AND,
			lane_pkg::XOR, lane_pkg::MUL, lane_pkg::CMPLT, lane_pkg::LDI, lane_pkg::MVS};
		int                lens [3] = '{1, 8, 16};
		logic [4:0]        d;
		int                len;
		void'($urandom(32'h10e7));
		cycles    = 0;
		cmd_valid = 1'b0;
		cmd_word  = '0;
		reset     = 1'b1;
		for (int i = 0; i < 32; i++) model_regs[i] = '0;
		model_mask = '1;
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;

		for (int i = 0; i < 4; i++) read_back(5'($urandom), 1);
		for (int i = 16; i < 32; i++) exec_cmd(imm_word(5'(i), 16'($urandom)));
		exec_cmd(vec_word(lane_pkg::ADD, 1'b1, 16, 5'd0, 5'd16, 5'd16));
		read_back(5'd0, 16);	// Mask out of reset lets every element write
		report_test("reset_state");

		for (int i = 0; i < 8; i++) begin
			d = 5'($urandom);
			exec_cmd(imm_word(d, {i[0], 15'($urandom)}));
			read_back(d, 1);
		end
		report_test("ldi_mvs");

		for (int k = 0; k < 15; k++) begin
			len = lens[k % 3];
			d   = 5'($urandom);
			exec_cmd(vec_word(all_ops[k / 3], 1'b0, len, d, pick_src(d, len), pick_src(d, len)));
			read_back(d, len);
		end
		report_test("vector_ops");

		exec_cmd(vec_word(lane_pkg::CMPLT, 1'b0, 16, 5'd0, 5'd0, 5'd16));
		exec_cmd(vec_word(lane_pkg::ADD, 1'b1, 16, 5'd0, 5'd16, 5'd16));
		read_back(5'd0, 16);
		report_test("masked_add");

		timed_add(1);
		timed_add(6);
		timed_add(16);
		report_test("commit_timing");

		for (int k = 0; k < 40; k++) begin
			len = int'($urandom % 16) + 1;
			d   = 5'($urandom);
			if (all_ops[k % 8 == 0 ? 6 : $urandom % 8] == lane_pkg::LDI) begin
				exec_cmd(imm_word(d, 16'($urandom)));
			end else begin
				exec_cmd(vec_word(all_ops[$urandom % 8], 1'($urandom), len, d,
					pick_src(d, len), pick_src(d, len)));
			end
		end
		read_back(5'd0, 32);
		report_test("random_seq");

		$display("checks %0d, mismatches %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// File: list.f
+incdir+.
lane_pkg.sv
lane_if.sv
lane_ctrl.sv
slice_counter.sv
reg_file.sv
mask_reg.sv
vec_alu.sv
lane_unit.sv
tb_lane_unit.sv

// File: run.sh
#!/bin/sh
# Build the lane testbench with Verilator, run it, then scan the log
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_lane_unit -f list.f -o sim_lane \
	&& ./obj_dir/sim_lane > sim.log 2>&1 \
	|| { echo "Build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1
grep -q "TEST PASS" sim.log || exit 1
exit 0
